// File: vid_config.svh
`ifndef VID_CONFIG_SVH
`define VID_CONFIG_SVH

// two 10-bit planes side by side
`define VID_DATA_W 20

// hsync edges seen after vid_locked before the input counts as locked
`define LOCK_HSYNCS 2

// kept small so a stalled stream side fills it within one frame
`define FIFO_DEPTH 16

// address width, FIFO_DEPTH must stay a power of two
`define FIFO_AW 4

`endif

// File: vid_pkg.sv
`include "vid_config.svh"

package vid_pkg;

    // video pins as sampled each clock
    typedef struct packed {
        logic [`VID_DATA_W-1:0] data;
        logic                   datavalid;
        logic                   h_sync;
        logic                   v_sync;
    } vid_in_t;

    // one stream beat, also the FIFO word
    typedef struct packed {
        logic [`VID_DATA_W-1:0] data;
        logic                   sop;
        logic                   eop;
    } st_beat_t;

    // one-cycle strobes from the registered syncs
    typedef struct packed {
        logic start_of_hsync;
        logic start_of_vsync;
        logic end_of_vsync;
    } sync_edges_t;

    typedef enum logic [1:0] {
        hunt,
        wait_frame,
        streaming
    } lock_state_t;

endpackage

// File: vid_input_stage.sv
`timescale 1ns/1ps

module vid_input_stage (
    input  logic                  rst_vid_clk,
    input  logic                  vid_clk_int,
    input  vid_pkg::vid_in_t      vid_in,
    output vid_pkg::vid_in_t      vid_q,
    output vid_pkg::sync_edges_t  edges
);

    logic h_sync_prev;
    logic v_sync_prev;

    // one register stage on every video pin
    always_ff @(posedge rst_vid_clk or posedge vid_clk_int) begin
        if (vid_clk_int) begin
            vid_q       <= '0;
            h_sync_prev <= 1'b0;
            v_sync_prev <= 1'b0;
        end else begin
            vid_q       <= vid_in;
            h_sync_prev <= vid_q.h_sync;
            v_sync_prev <= vid_q.v_sync;
        end
    end

    // edges line up with vid_q
    assign edges = '{
        start_of_hsync: vid_q.h_sync & ~h_sync_prev,
        start_of_vsync: vid_q.v_sync & ~v_sync_prev,
        end_of_vsync:   ~vid_q.v_sync & v_sync_prev
    };

endmodule

// File: hsync_lock_counter.sv
`timescale 1ns/1ps
`include "vid_config.svh"

module hsync_lock_counter (
    input  logic rst_vid_clk,
    input  logic vid_clk_int,
    input  logic start_of_hsync,
    input  logic restart,
    output logic hsyncs_seen
);

    localparam int cnt_w = $clog2(`LOCK_HSYNCS + 1);
    localparam logic [cnt_w-1:0] load_val = cnt_w'(`LOCK_HSYNCS);

    logic [cnt_w-1:0] cnt;

    // counts down to zero and sticks there
    always_ff @(posedge rst_vid_clk or posedge vid_clk_int) begin
        if (vid_clk_int) begin
            cnt <= load_val;
        end else if (restart) begin
            cnt <= load_val;
        end else if (start_of_hsync && cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign hsyncs_seen = (cnt == '0);

    a_no_wrap: assert property (@(posedge rst_vid_clk) disable iff (vid_clk_int)
        (cnt == '0 && !restart) |=> cnt == '0);

endmodule

// File: lock_fsm.sv
`timescale 1ns/1ps

module lock_fsm (
    input  logic                 rst_vid_clk,
    input  logic                 vid_clk_int,
    input  vid_pkg::sync_edges_t edges,
    input  logic                 vid_locked,
    input  logic                 hsyncs_seen,
    input  logic                 enable,
    input  logic                 overflow_event,
    input  logic                 full,
    output logic                 restart,
    output logic                 write_en,
    output logic                 abort
);

    import vid_pkg::*;

    lock_state_t state;
    lock_state_t state_n;
    logic        ovf_pending;
    logic        drain;
    logic        drop;

    // overflow recovery waits for the FIFO to make room
    assign drain = ovf_pending & ~full;
    assign drop  = ~vid_locked | drain;

    always_comb begin
        state_n = state;
        if (drop) begin
            state_n = hunt;
        end else begin
            case (state)
                hunt: begin
                    // restart still high means the count is stale
                    if (hsyncs_seen && !restart) begin
                        state_n = wait_frame;
                    end
                end
                wait_frame: begin
                    if (edges.end_of_vsync && enable) begin
                        state_n = streaming;
                    end
                end
                streaming: begin
                    if (edges.end_of_vsync && !enable) begin
                        state_n = wait_frame;
                    end
                end
                default: state_n = hunt;
            endcase
        end
    end

    always_ff @(posedge rst_vid_clk or posedge vid_clk_int) begin
        if (vid_clk_int) begin
            state       <= hunt;
            restart     <= 1'b0;
            ovf_pending <= 1'b0;
        end else begin
            state       <= state_n;
            // held while unlocked so the counter cannot run ahead
            restart     <= drop;
            ovf_pending <= (ovf_pending | overflow_event) & ~drain;
        end
    end

    assign write_en = (state == streaming) & ~ovf_pending;
    assign abort    = (state == streaming) & drop;

    a_abort_leaves: assert property (@(posedge rst_vid_clk) disable iff (vid_clk_int)
        abort |-> state == streaming ##1 state == hunt);

endmodule

// File: packet_writer.sv
`timescale 1ns/1ps
`include "vid_config.svh"

module packet_writer (
    input  logic                 rst_vid_clk,
    input  logic                 vid_clk_int,
    input  vid_pkg::vid_in_t     vid_q,
    input  vid_pkg::sync_edges_t edges,
    input  logic                 write_en,
    input  logic                 abort,
    input  logic                 full,
    output logic                 wr_req,
    output vid_pkg::st_beat_t    wr_beat
);

    logic [`VID_DATA_W-1:0] held;
    logic                   in_pkt;
    logic                   eop_wait;
    logic                   eop_req;
    logic                   flush;
    logic                   active;

    // packet end on a vsync edge, an abort, or a flush that found the FIFO full
    assign eop_req = in_pkt & (edges.start_of_vsync | edges.end_of_vsync | abort | eop_wait);
    assign flush   = eop_req & ~full;
    assign active  = write_en & vid_q.datavalid & ~eop_req;
    assign wr_req  = active | flush;

    // type word 0 opens the packet, later writes carry the held sample
    always_comb begin
        wr_beat.data = in_pkt ? held : '0;
        wr_beat.sop  = ~in_pkt;
        wr_beat.eop  = flush;
    end

    // a lost write keeps the held sample for the closing flush
    always_ff @(posedge rst_vid_clk) begin
        if (active && !full) begin
            held <= vid_q.data;
        end
    end

    always_ff @(posedge rst_vid_clk or posedge vid_clk_int) begin
        if (vid_clk_int) begin
            in_pkt   <= 1'b0;
            eop_wait <= 1'b0;
        end else if (flush) begin
            in_pkt   <= 1'b0;
            eop_wait <= 1'b0;
        end else if (eop_req) begin
            eop_wait <= 1'b1;
        end else if (active) begin
            in_pkt <= 1'b1;
        end
    end

    // outside streaming only one closing flush may write
    a_write_gated: assert property (@(posedge rst_vid_clk) disable iff (vid_clk_int)
        (wr_req && !write_en) |=> (!wr_req || write_en));

endmodule

// File: packet_fifo.sv
`timescale 1ns/1ps
`include "vid_config.svh"

module packet_fifo #(
    parameter type payload_t = vid_pkg::st_beat_t
) (
    input  logic     rst_vid_clk,
    input  logic     vid_clk_int,
    input  logic     wr_req,
    input  payload_t wr_beat,
    input  logic     clear_overflow,
    input  logic     st_ready,
    output logic     full,
    output logic     overflow_event,
    output logic     overflow,
    output payload_t st_out,
    output logic     st_valid
);

    localparam logic [`FIFO_AW:0] depth_val = (`FIFO_AW + 1)'(`FIFO_DEPTH);

    payload_t             mem [`FIFO_DEPTH];
    logic [`FIFO_AW-1:0]  wr_ptr;
    logic [`FIFO_AW-1:0]  rd_ptr;
    logic [`FIFO_AW:0]    count;
    logic                 push;
    logic                 pop;

    assign full           = (count == depth_val);
    assign overflow_event = wr_req & full;
    assign push           = wr_req & ~full;
    assign pop            = st_valid & st_ready;

    always_ff @(posedge rst_vid_clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_beat;
        end
    end

    always_ff @(posedge rst_vid_clk or posedge vid_clk_int) begin
        if (vid_clk_int) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // sticky until cleared
            overflow <= (overflow | overflow_event) & ~clear_overflow;
        end
    end

    // first word falls through
    assign st_out   = mem[rd_ptr];
    assign st_valid = (count != '0);

    a_stall_stable: assert property (@(posedge rst_vid_clk) disable iff (vid_clk_int)
        (st_valid && !st_ready) |=> st_valid && $stable(st_out));

endmodule

// File: vid_to_stream.sv
`timescale 1ns/1ps

module vid_to_stream (
    input  logic              rst_vid_clk,
    input  logic              vid_clk_int,
    input  vid_pkg::vid_in_t  vid_in,
    input  logic              vid_locked,
    input  logic              enable,
    input  logic              clear_overflow,
    input  logic              st_ready,
    output vid_pkg::st_beat_t st_out,
    output logic              st_valid,
    output logic              overflow
);

    import vid_pkg::*;

    vid_in_t     vid_q;
    sync_edges_t edges;
    logic        hsyncs_seen;
    logic        restart;
    logic        write_en;
    logic        abort;
    logic        full;
    logic        overflow_event;
    logic        wr_req;
    st_beat_t    wr_beat;

    vid_input_stage i_vid_input_stage (
        .rst_vid_clk (rst_vid_clk),
        .vid_clk_int (vid_clk_int),
        .vid_in      (vid_in),
        .vid_q       (vid_q),
        .edges       (edges)
    );

    hsync_lock_counter i_hsync_lock_counter (
        .rst_vid_clk    (rst_vid_clk),
        .vid_clk_int    (vid_clk_int),
        .start_of_hsync (edges.start_of_hsync),
        .restart        (restart),
        .hsyncs_seen    (hsyncs_seen)
    );

    lock_fsm i_lock_fsm (
        .rst_vid_clk    (rst_vid_clk),
        .vid_clk_int    (vid_clk_int),
        .edges          (edges),
        .vid_locked     (vid_locked),
        .hsyncs_seen    (hsyncs_seen),
        .enable         (enable),
        .overflow_event (overflow_event),
        .full           (full),
        .restart        (restart),
        .write_en       (write_en),
        .abort          (abort)
    );

    packet_writer i_packet_writer (
        .rst_vid_clk (rst_vid_clk),
        .vid_clk_int (vid_clk_int),
        .vid_q       (vid_q),
        .edges       (edges),
        .write_en    (write_en),
        .abort       (abort),
        .full        (full),
        .wr_req      (wr_req),
        .wr_beat     (wr_beat)
    );

    packet_fifo #(
        .payload_t (st_beat_t)
    ) i_packet_fifo (
        .rst_vid_clk    (rst_vid_clk),
        .vid_clk_int    (vid_clk_int),
        .wr_req         (wr_req),
        .wr_beat        (wr_beat),
        .clear_overflow (clear_overflow),
        .st_ready       (st_ready),
        .full           (full),
        .overflow_event (overflow_event),
        .overflow       (overflow),
        .st_out         (st_out),
        .st_valid       (st_valid)
    );

endmodule

// File: tb_vid_to_stream.sv
`timescale 1ns/1ps
`include "vid_config.svh"

module tb_vid_to_stream;

    import vid_pkg::*;

    localparam int n_rows = 8;

    logic     rst_vid_clk = 1'b0;
    logic     vid_clk_int;
    vid_in_t  vid_in;
    logic     vid_locked;
    logic     enable;
    logic     clear_overflow;
    logic     st_ready;
    st_beat_t st_out;
    logic     st_valid;
    logic     overflow;

    // per row: frames, active lines, samples per line, enable, ready mode
    // ready mode 0 always, 1 lfsr, 2 low through the active lines
    // lock drop and relock steps count from the start of the row, 0 means none
    // exp_mask bit f set when frame f of the row should come out as a packet
    string row_name  [n_rows] = '{"lock_up", "basic", "ready_lfsr", "disabled",
                                  "reenable", "unlock", "overflow", "after_ovf"};
    int    frames_t  [n_rows] = '{2, 2, 2, 1, 1, 2, 1, 2};
    int    lines_t   [n_rows] = '{2, 2, 3, 2, 2, 3, 4, 2};
    int    spl_t     [n_rows] = '{6, 6, 5, 6, 4, 6, 8, 6};
    int    enable_t  [n_rows] = '{1, 1, 1, 0, 1, 1, 1, 1};
    int    mode_t    [n_rows] = '{0, 0, 1, 0, 0, 0, 2, 1};
    int    drop_at   [n_rows] = '{1, 0, 0, 0, 0, 40, 0, 0};
    int    relock_at [n_rows] = '{5, 0, 0, 0, 0, 46, 0, 0};
    int    exp_mask  [n_rows] = '{2, 3, 3, 0, 1, 3, 1, 3};

    st_beat_t exp_q [$];
    int       row_q [$];

    logic [15:0] lfsr_state = 16'd23;
    int          errors = 0;
    int          row = 0;
    int          row_step = 0;
    bit          live;
    bit          pkt_open;
    bit          stall_now = 1'b0;
    st_beat_t    got_exp;
    int          got_row;

    vid_to_stream i_vid_to_stream (
        .rst_vid_clk    (rst_vid_clk),
        .vid_clk_int    (vid_clk_int),
        .vid_in         (vid_in),
        .vid_locked     (vid_locked),
        .enable         (enable),
        .clear_overflow (clear_overflow),
        .st_ready       (st_ready),
        .st_out         (st_out),
        .st_valid       (st_valid),
        .overflow       (overflow)
    );

    always #5 rst_vid_clk = ~rst_vid_clk;

    // galois form, taps 16 14 13 11
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = (lfsr_state >> 1) ^ (b ? 16'hB400 : 16'h0000);
        return b;
    endfunction

    function automatic logic [`VID_DATA_W-1:0] next_sample();
        logic [`VID_DATA_W-1:0] v;
        for (int i = 0; i < `VID_DATA_W; i++) begin
            v[i] = lfsr_bit();
        end
        return v;
    endfunction

    function automatic int line_len(int r);
        return spl_t[r] + 5;
    endfunction

    function automatic int total_steps();
        int t;
        t = 40;
        for (int r = 0; r < n_rows; r++) begin
            t += frames_t[r] * ((lines_t[r] + 2) * line_len(r) + 8);
        end
        return t;
    endfunction

    task automatic push_beat(input logic [`VID_DATA_W-1:0] d, input bit sop, input bit eop);
        st_beat_t b;
        b.data = d;
        b.sop  = sop;
        b.eop  = eop;
        exp_q.push_back(b);
        row_q.push_back(row);
    endtask

    task automatic mark_eop();
        st_beat_t b;
        b = exp_q.pop_back();
        b.eop = 1'b1;
        exp_q.push_back(b);
        pkt_open = 1'b0;
    endtask

    task automatic step_clock();
        @(posedge rst_vid_clk);
        #1;
        row_step++;
        if (drop_at[row] != 0 && row_step == drop_at[row]) begin
            vid_locked = 1'b0;
            if (pkt_open) begin
                mark_eop();
            end
            live = 1'b0;
        end
        if (drop_at[row] != 0 && row_step == relock_at[row]) begin
            vid_locked = 1'b1;
        end
        st_ready = (mode_t[row] == 1) ? lfsr_bit() : !stall_now;
    endtask

    task automatic run_frame(input int f);
        bit vs;
        bit dv;
        int kept;
        live     = exp_mask[row][f];
        pkt_open = 1'b0;
        kept     = 0;
        for (int li = 0; li < lines_t[row] + 2; li++) begin
            vs = (li < 2);
            stall_now = (mode_t[row] == 2) && !vs;
            for (int k = 0; k < line_len(row); k++) begin
                step_clock();
                dv = !vs && k >= 5;
                vid_in.v_sync    = vs;
                vid_in.h_sync    = (k < 2);
                vid_in.datavalid = dv;
                vid_in.data      = dv ? next_sample() : '0;
                // a sample one step before the lock drop never leaves the input register
                if (dv && live && row_step + 1 != drop_at[row]) begin
                    // type word plus FIFO_DEPTH samples survive a stalled frame
                    if (mode_t[row] != 2 || kept < `FIFO_DEPTH) begin
                        if (!pkt_open) begin
                            push_beat('0, 1'b1, 1'b0);
                            pkt_open = 1'b1;
                        end
                        push_beat(vid_in.data, 1'b0, 1'b0);
                        kept++;
                    end
                end
            end
        end
        if (live && pkt_open) begin
            mark_eop();
        end
        stall_now = 1'b0;
        for (int t = 0; t < 8; t++) begin
            step_clock();
            vid_in = '0;
            if (mode_t[row] == 2) begin
                if (t == 0 && overflow !== 1'b1) begin
                    $display("[FAIL] %s: expected overflow 1 actual %b", row_name[row], overflow);
                    errors++;
                end
                clear_overflow = (t == 1);
                if (t == 3 && overflow !== 1'b0) begin
                    $display("[FAIL] %s: expected overflow 0 actual %b", row_name[row], overflow);
                    errors++;
                end
            end
        end
    endtask

    always @(posedge rst_vid_clk) begin
        if (!vid_clk_int && st_valid && st_ready) begin
            if (exp_q.size() == 0) begin
                $display("unexpected beat with data %h while no packet was due", st_out.data);
                errors++;
            end else begin
                got_exp = exp_q.pop_front();
                got_row = row_q.pop_front();
                if (st_out !== got_exp) begin
                    $display("[FAIL] %s: expected %h actual %h", row_name[got_row], got_exp,
                             st_out);
                    errors++;
                end
            end
        end
    end

    initial begin
        #(total_steps() * 4 * 10);
        $display("timeout: stream did not finish, %0d beats still due", exp_q.size());
        $display("Checks failed");
        $finish;
    end

    initial begin
        vid_clk_int    = 1'b1;
        vid_in         = '0;
        vid_locked     = 1'b0;
        enable         = 1'b0;
        clear_overflow = 1'b0;
        st_ready       = 1'b1;
        repeat (2) @(posedge rst_vid_clk);
        #1;
        vid_clk_int = 1'b0;
        for (row = 0; row < n_rows; row++) begin
            row_step = 0;
            enable   = enable_t[row];
            for (int f = 0; f < frames_t[row]; f++) begin
                run_frame(f);
            end
        end
        row = n_rows - 1;
        // closing vsync flushes the last packet
        for (int k = 0; k < 2 * line_len(row); k++) begin
            step_clock();
            vid_in.v_sync = 1'b1;
            vid_in.h_sync = (k % line_len(row)) < 2;
        end
        while (exp_q.size() != 0) begin
            step_clock();
            vid_in = '0;
        end
        repeat (20) step_clock();
        if (overflow !== 1'b0) begin
            $display("[FAIL] end: expected overflow 0 actual %b", overflow);
            errors++;
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+.
vid_pkg.sv
vid_input_stage.sv
hsync_lock_counter.sv
lock_fsm.sv
packet_writer.sv
packet_fifo.sv
vid_to_stream.sv
tb_vid_to_stream.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_vid_to_stream
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
